//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing
LINTFLAGS = --lint-only --timing -Wall
TOP       = bitsyncTb
FLIST     = flist.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- flist.f
hdl/bitsyncPkg.sv
hdl/apbSlave.sv
hdl/bitsyncRegs.sv
hdl/strobeTimer.sv
hdl/dcLoopFilter.sv
hdl/dacOutputMux.sv
hdl/bitsyncTop.sv
tb/bitsyncTb.sv

//--- hdl/apbSlave.sv
module apbSlave
    import bitsyncPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     psel,
    input  logic     penable,
    input  logic     pwrite,
    input  busWord_t readData,
    input  logic     addrError,
    output logic     pready,
    output busWord_t prdata,
    output logic     pslverr,
    output logic     regWrite,
    output logic     regRead
);

    apbState_e state;
    apbState_e stateNext;

    // Setup phase arms the FSM, so WAIT is the first access cycle
    always_comb begin
        stateNext = state;
        case (state)
            APB_IDLE: begin
                if (psel && !penable) begin
                    stateNext = APB_WAIT;
                end
            end
            APB_WAIT: begin
                // Master dropped the transfer
                if (psel && penable) begin
                    stateNext = APB_DONE;
                end else begin
                    stateNext = APB_IDLE;
                end
            end
            default: stateNext = APB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= APB_IDLE;
        end else begin
            state <= stateNext;
        end
    end

    // Response and register strobes only in the completion cycle
    assign pready   = (state == APB_DONE);
    assign regWrite = pready && pwrite;
    assign regRead  = pready && !pwrite;
    assign prdata   = pready ? readData : '0;
    assign pslverr  = pready && addrError;

endmodule

//--- hdl/bitsyncPkg.sv
package bitsyncPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic signed [17:0] sample_t;
    typedef logic signed [39:0] accum_t;
    typedef logic [4:0]         dcGain_t;
    typedef logic [7:0]         dcTest_t;
    typedef logic [3:0]         dacSel_t;
    typedef logic [15:0]        rate_t;
    typedef logic [4:0]         regAddr_t;
    typedef logic [31:0]        busWord_t;

    typedef enum logic [1:0] {
        MODE_DUAL_SYNC  = 2'd0,
        MODE_IND_CH     = 2'd1,
        MODE_SINGLE_CH  = 2'd2,
        MODE_OQPSK_SYNC = 2'd3
    } bitsyncMode_e;

    // Only two monitor sources remain
    typedef enum logic [3:0] {
        DAC_ADC = 4'd0,
        DAC_DC  = 4'd1
    } dacSource_e;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_WAIT,
        APB_DONE
    } apbState_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam regAddr_t REG_CTRL     = 5'h00;
    localparam regAddr_t REG_CH0_CFG  = 5'h04;
    localparam regAddr_t REG_CH1_CFG  = 5'h08;
    localparam regAddr_t REG_CH0_RATE = 5'h0C;
    localparam regAddr_t REG_CH1_RATE = 5'h10;

    // DC loop scaling
    localparam int DC_IN_SHIFT   = 16;
    localparam int DC_OUT_LSB    = 22;
    localparam int DC_TEST_SHIFT = 10;

    typedef struct packed {
        dacSel_t [2:0] dacSel;
        logic          dcEnable;
        logic          highImpedance;
        logic          singleEnded;
        dcGain_t       dcGain;
        dcTest_t       dcTest;
    } chanCfg_t;

    typedef struct packed {
        logic [2:0]    dacEn;
        sample_t [2:0] dacData;
    } dacBus_t;

    // Channel 1 keeps its own timing in these modes
    function automatic logic asyncMode(bitsyncMode_e mode);
        return (mode == MODE_IND_CH) || (mode == MODE_SINGLE_CH);
    endfunction

endpackage

//--- hdl/bitsyncRegs.sv
module bitsyncRegs
    import bitsyncPkg::*;
(
    input  logic         clk,
    input  logic         rstN,
    input  logic         regWrite,
    input  logic         regRead,
    input  regAddr_t     addr,
    input  busWord_t     wdata,
    input  logic [3:0]   strb,
    output busWord_t     readData,
    output logic         addrError,
    output bitsyncMode_e mode,
    output chanCfg_t     ch0Cfg,
    output chanCfg_t     ch1Cfg,
    output rate_t        ch0Rate,
    output rate_t        ch1Rate
);

    // Implemented bits per register
    localparam busWord_t CTRL_MASK = 32'h0000_0003;
    localparam busWord_t CFG_MASK  = 32'hFF1F_7FFF;
    localparam busWord_t RATE_MASK = 32'h0000_FFFF;

    busWord_t ctrlReg;
    busWord_t ch0CfgReg;
    busWord_t ch1CfgReg;
    busWord_t ch0RateReg;
    busWord_t ch1RateReg;
    busWord_t readMux;
    logic     addrHit;

    function automatic busWord_t mergeBytes(busWord_t old, busWord_t data,
                                            logic [3:0] byteEn, busWord_t mask);
        busWord_t merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (byteEn[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged & mask;
    endfunction

    function automatic chanCfg_t unpackCfg(busWord_t word);
        chanCfg_t cfg;
        cfg.dacSel[0]     = word[3:0];
        cfg.dacSel[1]     = word[7:4];
        cfg.dacSel[2]     = word[11:8];
        cfg.dcEnable      = word[12];
        cfg.highImpedance = word[13];
        cfg.singleEnded   = word[14];
        cfg.dcGain        = word[20:16];
        cfg.dcTest        = word[31:24];
        return cfg;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrlReg    <= '0;
            ch0CfgReg  <= '0;
            ch1CfgReg  <= '0;
            ch0RateReg <= '0;
            ch1RateReg <= '0;
        end else if (regWrite) begin
            case (addr)
                REG_CTRL:     ctrlReg    <= mergeBytes(ctrlReg, wdata, strb, CTRL_MASK);
                REG_CH0_CFG:  ch0CfgReg  <= mergeBytes(ch0CfgReg, wdata, strb, CFG_MASK);
                REG_CH1_CFG:  ch1CfgReg  <= mergeBytes(ch1CfgReg, wdata, strb, CFG_MASK);
                REG_CH0_RATE: ch0RateReg <= mergeBytes(ch0RateReg, wdata, strb, RATE_MASK);
                REG_CH1_RATE: ch1RateReg <= mergeBytes(ch1RateReg, wdata, strb, RATE_MASK);
                default: ;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Readback and decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        readMux = '0;
        addrHit = 1'b1;
        case (addr)
            REG_CTRL:     readMux = ctrlReg;
            REG_CH0_CFG:  readMux = ch0CfgReg;
            REG_CH1_CFG:  readMux = ch1CfgReg;
            REG_CH0_RATE: readMux = ch0RateReg;
            REG_CH1_RATE: readMux = ch1RateReg;
            default:      addrHit = 1'b0;
        endcase
    end

    assign readData  = regRead ? readMux : '0;
    assign addrError = (regWrite || regRead) && !addrHit;

    assign mode    = bitsyncMode_e'(ctrlReg[1:0]);
    assign ch0Cfg  = unpackCfg(ch0CfgReg);
    assign ch1Cfg  = unpackCfg(ch1CfgReg);
    assign ch0Rate = ch0RateReg[15:0];
    assign ch1Rate = ch1RateReg[15:0];

endmodule

//--- hdl/bitsyncTop.sv
module bitsyncTop
    import bitsyncPkg::*;
#(
    parameter int NumDacs = 3
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  regAddr_t   paddr,
    input  busWord_t   pwdata,
    input  logic [3:0] pstrb,
    input  logic       clkEn,
    input  sample_t    rx0,
    input  sample_t    rx1,
    output busWord_t   prdata,
    output logic       pready,
    output logic       pslverr,
    output logic       ch0DcEn,
    output logic       ch1DcEn,
    output sample_t    ch0Offset,
    output sample_t    ch1Offset,
    output dacBus_t    ch0Dac,
    output dacBus_t    ch1Dac,
    output logic       ch0HighImpedance,
    output logic       ch0SingleEnded,
    output logic       ch1HighImpedance,
    output logic       ch1SingleEnded
);

    logic         regWrite;
    logic         regRead;
    busWord_t     readData;
    logic         addrError;
    bitsyncMode_e mode;
    chanCfg_t     ch0Cfg;
    chanCfg_t     ch1Cfg;
    rate_t        ch0Rate;
    rate_t        ch1Rate;
    logic         ch1TimerEn;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus and registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    apbSlave apb (
        .clk(clk), .rstN(rstN),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .readData(readData), .addrError(addrError),
        .pready(pready), .prdata(prdata), .pslverr(pslverr),
        .regWrite(regWrite), .regRead(regRead)
    );

    bitsyncRegs regs (
        .clk(clk), .rstN(rstN),
        .regWrite(regWrite), .regRead(regRead),
        .addr(paddr), .wdata(pwdata), .strb(pstrb),
        .readData(readData), .addrError(addrError),
        .mode(mode),
        .ch0Cfg(ch0Cfg), .ch1Cfg(ch1Cfg),
        .ch0Rate(ch0Rate), .ch1Rate(ch1Rate)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Loop strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    strobeTimer ch0Timer (
        .clk(clk), .rstN(rstN), .clkEn(clkEn), .rate(ch0Rate), .dcEn(ch0DcEn)
    );

    strobeTimer ch1Timer (
        .clk(clk), .rstN(rstN), .clkEn(clkEn), .rate(ch1Rate), .dcEn(ch1TimerEn)
    );

    // Synchronous modes run channel 1 on channel 0 timing
    assign ch1DcEn = asyncMode(mode) ? ch1TimerEn : ch0DcEn;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // DC loops and DAC monitors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    dcLoopFilter ch0DcLoop (
        .clk(clk), .rstN(rstN), .dcEn(ch0DcEn), .rx(rx0),
        .enable(ch0Cfg.dcEnable), .gain(ch0Cfg.dcGain), .testValue(ch0Cfg.dcTest),
        .offset(ch0Offset)
    );

    dcLoopFilter ch1DcLoop (
        .clk(clk), .rstN(rstN), .dcEn(ch1DcEn), .rx(rx1),
        .enable(ch1Cfg.dcEnable), .gain(ch1Cfg.dcGain), .testValue(ch1Cfg.dcTest),
        .offset(ch1Offset)
    );

    dacOutputMux #(.NumDacs(NumDacs)) ch0DacMux (
        .clk(clk), .rstN(rstN), .cfg(ch0Cfg), .rx(rx0), .clkEn(clkEn),
        .offset(ch0Offset), .dcEn(ch0DcEn), .dac(ch0Dac)
    );

    dacOutputMux #(.NumDacs(NumDacs)) ch1DacMux (
        .clk(clk), .rstN(rstN), .cfg(ch1Cfg), .rx(rx1), .clkEn(clkEn),
        .offset(ch1Offset), .dcEn(ch1DcEn), .dac(ch1Dac)
    );

    assign ch0HighImpedance = ch0Cfg.highImpedance;
    assign ch0SingleEnded   = ch0Cfg.singleEnded;
    assign ch1HighImpedance = ch1Cfg.highImpedance;
    assign ch1SingleEnded   = ch1Cfg.singleEnded;

endmodule

//--- hdl/dacOutputMux.sv
module dacOutputMux
    import bitsyncPkg::*;
#(
    parameter int NumDacs = 3
) (
    input  logic     clk,
    input  logic     rstN,
    input  chanCfg_t cfg,
    input  sample_t  rx,
    input  logic     clkEn,
    input  sample_t  offset,
    input  logic     dcEn,
    output dacBus_t  dac
);

    logic [2:0]    enNext;
    sample_t [2:0] dataNext;
    logic [2:0]    enReg;
    sample_t [2:0] dataReg;

    // Unused DAC slots stay idle at zero
    always_comb begin
        enNext   = '0;
        dataNext = '0;
        for (int i = 0; i < NumDacs; i++) begin
            if (cfg.dacSel[i] == dacSel_t'(DAC_DC)) begin
                enNext[i]   = dcEn;
                dataNext[i] = offset;
            end else begin
                // ADC source, also for any unknown code
                enNext[i]   = clkEn;
                dataNext[i] = rx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            enReg <= '0;
        end else begin
            enReg <= enNext;
        end
    end

    always_ff @(posedge clk) begin
        dataReg <= dataNext;
    end

    assign dac.dacEn   = enReg;
    assign dac.dacData = dataReg;

endmodule

//--- hdl/dcLoopFilter.sv
module dcLoopFilter
    import bitsyncPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    dcEn,
    input  sample_t rx,
    input  logic    enable,
    input  dcGain_t gain,
    input  dcTest_t testValue,
    output sample_t offset
);

    accum_t  accum;
    accum_t  accumNext;
    accum_t  dcIn;
    sample_t testOffset;

    // Input sign extended and placed above the fraction bits
    assign dcIn       = accum_t'(rx) <<< DC_IN_SHIFT;
    assign testOffset = {testValue, {DC_TEST_SHIFT{1'b0}}};

    always_comb begin
        accumNext = accum;
        if (dcEn) begin
            if (enable) begin
                accumNext = accum + (dcIn >>> gain);
            end else begin
                accumNext = '0;
            end
        end
    end

    // Offset tracks the new accumulator value, not the old one
    always_ff @(posedge clk) begin
        if (!rstN) begin
            accum  <= '0;
            offset <= '0;
        end else begin
            accum  <= accumNext;
            offset <= (testValue != '0) ? testOffset
                                        : accumNext[DC_OUT_LSB +: $bits(sample_t)];
        end
    end

endmodule

//--- hdl/strobeTimer.sv
module strobeTimer
    import bitsyncPkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  logic  clkEn,
    input  rate_t rate,
    output logic  dcEn
);

    rate_t count;

    // One strobe per rate + 1 sample enables
    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= rate;
            dcEn  <= 1'b0;
        end else begin
            dcEn <= 1'b0;
            if (clkEn) begin
                if (count == '0) begin
                    count <= rate;
                    dcEn  <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

endmodule

//--- tb/bitsyncTb.sv
module bitsyncTb
    import bitsyncPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        string      name;
        logic [1:0] mode;
        busWord_t   cfg0;
        busWord_t   cfg1;
        rate_t      rate0;
        rate_t      rate1;
        sample_t    rx0;
        sample_t    rx1;
        int         strobes;
        logic       checkOffset;
        sample_t    expOffset;
    } stimRow_t;

    // Reset, register checks and bus traffic before the table
    localparam int SETUP_CYCLES = 400;

    logic       clk;
    logic       rstN    = 1'b0;
    logic       psel    = 1'b0;
    logic       penable = 1'b0;
    logic       pwrite  = 1'b0;
    regAddr_t   paddr   = '0;
    busWord_t   pwdata  = '0;
    logic [3:0] pstrb   = '0;
    logic       clkEn   = 1'b0;
    sample_t    rx0     = '0;
    sample_t    rx1     = '0;
    busWord_t   prdata;
    logic       pready;
    logic       pslverr;
    logic       ch0DcEn;
    logic       ch1DcEn;
    sample_t    ch0Offset;
    sample_t    ch1Offset;
    dacBus_t    ch0Dac;
    dacBus_t    ch1Dac;
    logic       ch0HighImpedance;
    logic       ch0SingleEnded;
    logic       ch1HighImpedance;
    logic       ch1SingleEnded;

    stimRow_t    rows[$];
    string       testName   = "startup";
    int          errorCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    logic        sampling   = 1'b0;
    logic [15:0] lfsr       = 16'd73;

    // Expected register contents and reference model state
    busWord_t   shadow [5]     = '{default: '0};
    accum_t     accModel [2];
    sample_t    offExp [2];
    logic [2:0] enExp [2];
    sample_t    dataExp [2][3];
    int         clkCount [2]   = '{default: 0};
    int         pulseCount [2] = '{default: 0};
    logic       havePrev [2]   = '{default: 1'b0};

    bitsyncTop #(.NumDacs(3)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [15:0] lfsrStep(logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    // Bits that exist in each register
    function automatic busWord_t fieldMask(int idx);
        case (idx)
            0:       return 32'h0000_0003;
            1, 2:    return 32'hFF1F_7FFF;
            default: return 32'h0000_FFFF;
        endcase
    endfunction

    function automatic logic isMapped(regAddr_t addr);
        return (addr[1:0] == 2'b00) && (addr <= REG_CH1_RATE);
    endfunction

    function automatic int cycleBudget();
        int total;
        total = SETUP_CYCLES;
        foreach (rows[r]) begin
            total += (int'(rows[r].rate0) + 1) * rows[r].strobes * 8 + 200;
        end
        return total;
    endfunction

    task automatic stopOnFailure(string why);
        errorCount++;
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic reportMismatch(string what, longint expVal, longint actVal);
        stopOnFailure($sformatf("MISMATCH %s %s: expected %0d, actual %0d",
                                testName, what, expVal, actVal));
    endtask

    task automatic addRow(string name, logic [1:0] mode, busWord_t cfg0, busWord_t cfg1,
                          rate_t rate0, rate_t rate1, sample_t x0, sample_t x1,
                          int strobes, logic checkOffset, sample_t expOffset);
        stimRow_t row;
        row.name        = name;
        row.mode        = mode;
        row.cfg0        = cfg0;
        row.cfg1        = cfg1;
        row.rate0       = rate0;
        row.rate1       = rate1;
        row.rx0         = x0;
        row.rx1         = x1;
        row.strobes     = strobes;
        row.checkOffset = checkOffset;
        row.expOffset   = expOffset;
        rows.push_back(row);
    endtask

    // name, mode, ch0 cfg, ch1 cfg, rates, rx values, ch0 strobes, offset check
    task automatic loadRows();
        addRow("accumGain2", 2'd0, 32'h0002_1010, 32'h0003_1110, 16'd3, 16'd9,
               18'sd20000, -18'sd12000, 6, 1'b0, '0);
        addRow("indRates", 2'd1, 32'h0002_1010, 32'h0001_1011, 16'd5, 16'd2,
               -18'sd30000, 18'sd7000, 4, 1'b0, '0);
        addRow("testOverride", 2'd1, 32'h5A02_1010, 32'h8102_1110, 16'd1, 16'd1,
               18'sd100000, -18'sd3000, 3, 1'b1, 18'h16800);
        addRow("overrideOff", 2'd3, 32'h0004_1010, 32'h0003_1110, 16'd0, 16'd4,
               18'sd50000, 18'sd600, 5, 1'b0, '0);
        addRow("dcDisable", 2'd2, 32'h0004_2F17, 32'h0003_2110, 16'd2, 16'd0,
               18'sd1234, -18'sd1, 2, 1'b1, '0);
        addRow("unknownSel", 2'd0, 32'h0000_5C31, 32'h0001_7A19, 16'd7, 16'd3,
               -18'sd777, 18'sd4321, 3, 1'b0, '0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic busAccess(input logic write, input regAddr_t addr, input busWord_t wdata,
                             input logic [3:0] strb, output busWord_t rdata,
                             output logic err);
        int       idx;
        busWord_t byteMask;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        pstrb   <= strb;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        // Register takes the write on this edge
        if (write && isMapped(addr)) begin
            idx      = int'(addr) >> 2;
            byteMask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
            shadow[idx] = ((shadow[idx] & ~byteMask) | (wdata & byteMask)) & fieldMask(idx);
        end
    endtask

    task automatic writeReg(regAddr_t addr, busWord_t data, logic [3:0] strb);
        busWord_t rd;
        logic     err;
        busAccess(1'b1, addr, data, strb, rd, err);
        assert (!err) else stopOnFailure($sformatf("write to 0x%0h gave a slave error", addr));
    endtask

    task automatic checkAllRegs();
        busWord_t rd;
        logic     err;
        for (int a = 0; a < 5; a++) begin
            busAccess(1'b0, regAddr_t'(a * 4), '0, 4'h0, rd, err);
            assert (!err) else stopOnFailure("read of a mapped register gave a slave error");
            assert (rd == shadow[a])
                else reportMismatch($sformatf("read of 0x%0h", a * 4),
                                    longint'(shadow[a]), longint'(rd));
        end
    endtask

    task automatic runRow(stimRow_t row);
        testName = row.name;
        writeReg(REG_CTRL, {30'b0, row.mode}, 4'hF);
        writeReg(REG_CH0_RATE, {16'b0, row.rate0}, 4'hF);
        writeReg(REG_CH1_RATE, {16'b0, row.rate1}, 4'hF);
        writeReg(REG_CH0_CFG, row.cfg0, 4'hF);
        writeReg(REG_CH1_CFG, row.cfg1, 4'hF);
        rx0 <= row.rx0;
        rx1 <= row.rx1;
        // First interval after a rate change is partial
        havePrev[0]   = 1'b0;
        havePrev[1]   = 1'b0;
        pulseCount[0] = 0;
        sampling <= 1'b1;
        while (pulseCount[0] < row.strobes) begin
            @(posedge clk);
        end
        sampling <= 1'b0;
        repeat (3) @(posedge clk);
        if (row.checkOffset) begin
            @(negedge clk);
            assert (ch0Offset == row.expOffset)
                else reportMismatch("ch0 offset at row end",
                                    longint'(row.expOffset), longint'(ch0Offset));
        end
        repeat (2) @(posedge clk);
    endtask

    // Sample enables from the LFSR, one bit per cycle
    always @(posedge clk) begin
        if (sampling) begin
            lfsr = lfsrStep(lfsr);
            clkEn <= lfsr[0];
        end else begin
            clkEn <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            stopOnFailure($sformatf("timeout, run did not finish within %0d cycles",
                                    cycleLimit));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin : modelCheck
        sample_t  offNow [2];
        dacBus_t  dacNow [2];
        logic     strobe [2];
        sample_t  rxNow [2];
        busWord_t cfgW;
        logic     asyncNow;
        int       rateNow;
        offNow[0] = ch0Offset;
        offNow[1] = ch1Offset;
        dacNow[0] = ch0Dac;
        dacNow[1] = ch1Dac;
        strobe[0] = ch0DcEn;
        strobe[1] = ch1DcEn;
        rxNow[0]  = rx0;
        rxNow[1]  = rx1;
        asyncNow  = (shadow[0][1:0] == 2'd1) || (shadow[0][1:0] == 2'd2);
        if (!rstN) begin
            for (int c = 0; c < 2; c++) begin
                accModel[c] = '0;
                offExp[c]   = '0;
                enExp[c]    = '0;
            end
        end else begin
            if (!psel) begin
                assert (!pready && !pslverr)
                    else stopOnFailure("pready or pslverr high outside a transfer");
            end
            if (!asyncNow) begin
                assert (ch1DcEn == ch0DcEn)
                    else stopOnFailure("ch1 strobe did not follow ch0 in a synchronous mode");
            end
            assert (ch0HighImpedance == shadow[1][13] && ch0SingleEnded == shadow[1][14] &&
                    ch1HighImpedance == shadow[2][13] && ch1SingleEnded == shadow[2][14])
                else stopOnFailure("pad control outputs do not match their registers");
            for (int c = 0; c < 2; c++) begin
                cfgW    = shadow[1 + c];
                rateNow = int'(shadow[3 + c][15:0]);
                assert (offNow[c] == offExp[c])
                    else reportMismatch($sformatf("ch%0d offset", c),
                                        longint'(offExp[c]), longint'(offNow[c]));
                for (int i = 0; i < 3; i++) begin
                    assert (dacNow[c].dacEn[i] == enExp[c][i])
                        else reportMismatch($sformatf("ch%0d dac%0d enable", c, i),
                                            longint'(enExp[c][i]),
                                            longint'(dacNow[c].dacEn[i]));
                    if (enExp[c][i]) begin
                        assert (dacNow[c].dacData[i] == dataExp[c][i])
                            else reportMismatch($sformatf("ch%0d dac%0d data", c, i),
                                                longint'(dataExp[c][i]),
                                                longint'(dacNow[c].dacData[i]));
                    end
                end
                // Strobe spacing in sample enables
                if (strobe[c]) begin
                    pulseCount[c]++;
                    if (havePrev[c] && (c == 0 || asyncNow)) begin
                        assert (clkCount[c] == rateNow + 1)
                            else reportMismatch($sformatf("ch%0d clkEn per strobe", c),
                                                longint'(rateNow + 1), longint'(clkCount[c]));
                    end
                    clkCount[c] = 0;
                    havePrev[c] = 1'b1;
                end
                if (clkEn) begin
                    clkCount[c]++;
                end
                // DAC registers one cycle after their source
                for (int i = 0; i < 3; i++) begin
                    if (cfgW[4*i +: 4] == 4'd1) begin
                        enExp[c][i]   = strobe[c];
                        dataExp[c][i] = offExp[c];
                    end else begin
                        enExp[c][i]   = clkEn;
                        dataExp[c][i] = rxNow[c];
                    end
                end
                if (strobe[c]) begin
                    if (cfgW[12]) begin
                        accModel[c] = accModel[c] +
                                      ((accum_t'(rxNow[c]) <<< 16) >>> cfgW[20:16]);
                    end else begin
                        accModel[c] = '0;
                    end
                end
                if (cfgW[31:24] != 8'h00) begin
                    offExp[c] = sample_t'({cfgW[31:24], 10'b0});
                end else begin
                    offExp[c] = accModel[c][39:22];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : mainSequence
        busWord_t rd;
        logic     err;
        loadRows();
        cycleLimit = cycleBudget();
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);

        testName = "resetValues";
        checkAllRegs();

        testName = "byteStrobes";
        writeReg(REG_CH0_CFG, 32'hFFFF_FFFF, 4'b0101);
        writeReg(REG_CH1_RATE, 32'hABCD_1234, 4'b0010);
        writeReg(REG_CTRL, 32'h0000_00FF, 4'b1110);
        checkAllRegs();

        testName = "unmappedAccess";
        busAccess(1'b1, 5'h14, 32'hFFFF_FFFF, 4'hF, rd, err);
        assert (err) else stopOnFailure("write to 0x14 gave no slave error");
        busAccess(1'b1, 5'h06, 32'hFFFF_FFFF, 4'hF, rd, err);
        assert (err) else stopOnFailure("write to 0x06 gave no slave error");
        busAccess(1'b0, 5'h1C, '0, 4'h0, rd, err);
        assert (err) else stopOnFailure("read of 0x1C gave no slave error");
        checkAllRegs();

        foreach (rows[r]) begin
            runRow(rows[r]);
        end

        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
